/* common/dsp_pkg.sv */
package dsp_pkg;

    typedef logic signed [15:0] sample_t;
    typedef logic signed [15:0] amp_t;    // q1.15.
    typedef logic signed [31:0] acc_t;

    typedef enum logic [3:0] {
        PLAY = 4'h1,
        ACQ  = 4'h2,
        WAIT = 4'h3,
        DONE = 4'h4
    } opcode_e;

    // pulse view, opcode in word 3.
    typedef struct packed {
        opcode_e     opcode;
        logic [9:0]  env_start;
        logic [9:0]  env_len;
        amp_t        amp;
        logic [87:0] pad;
    } play_cmd_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [31:0] count;   // acquire length or wait cycles.
        logic [91:0] pad;
    } ctrl_cmd_t;

    typedef union packed {
        play_cmd_t play;
        ctrl_cmd_t ctrl;
    } cmd_u;

    typedef struct packed {
        logic    valid;
        sample_t data;
    } dac_out_t;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

    localparam int BUF_AW = 10;

    typedef enum logic [2:0] {
        CMD_MEM = 3'd0,
        ENV_MEM = 3'd1
    } mem_sel_e;

    typedef struct packed {
        logic        en;
        logic [2:0]  core;
        mem_sel_e    sel;
        logic [15:0] addr;
        logic [31:0] data;
    } host_wr_t;

    typedef struct packed {
        logic              we;
        logic [BUF_AW-1:0] addr;
        dsp_pkg::sample_t  data;
    } acq_wr_t;

    typedef struct packed {
        logic              we;
        logic [BUF_AW-1:0] addr;
        dsp_pkg::acc_t     data;
    } acc_wr_t;

endpackage

/* source/aligned_ram.sv */
module aligned_ram #(
    parameter int DIN_WIDTH       = 32,
    parameter int N_DIN_TO_DOUT   = 4,
    parameter int DOUT_ADDR_WIDTH = 6,
    parameter int READ_LATENCY    = 2
) (
    input  logic                                          clk,
    input  logic [DIN_WIDTH-1:0]                          write_data,
    input  logic [DOUT_ADDR_WIDTH+$clog2(N_DIN_TO_DOUT)-1:0] write_addr,
    input  logic                                          write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0]                    read_addr,
    output logic [DIN_WIDTH*N_DIN_TO_DOUT-1:0]            read_data
);

    localparam int LANE_W = $clog2(N_DIN_TO_DOUT);
    localparam int DEPTH  = 2 ** (DOUT_ADDR_WIDTH + LANE_W);

    logic [DIN_WIDTH-1:0]               mem [DEPTH];
    logic [DIN_WIDTH*N_DIN_TO_DOUT-1:0] pipe [READ_LATENCY];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;    // powers up cleared.
        end
    end

    // low address bits select the lane.
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < N_DIN_TO_DOUT; j++) begin
            pipe[0][j*DIN_WIDTH +: DIN_WIDTH] <= mem[read_addr * N_DIN_TO_DOUT + j];
        end
        for (int s = 1; s < READ_LATENCY; s++) begin
            pipe[s] <= pipe[s-1];
        end
    end

    assign read_data = pipe[READ_LATENCY-1];

endmodule

/* proc_core/elem_mems.sv */
module elem_mems
    import dsp_pkg::*;
    import mem_pkg::*;
#(
    parameter int CORE_ID    = 0,
    parameter int CMD_ADDR_W = 6,
    parameter int ENV_ADDR_W = 10
) (
    input  logic                  clk,
    input  host_wr_t              host_wr,
    input  logic [CMD_ADDR_W-1:0] cmd_addr,
    output cmd_u                  cmd_data,
    input  logic [ENV_ADDR_W-1:0] env_addr,
    output sample_t               env_data
);

    logic        core_hit;
    logic        cmd_we;
    logic        env_we;
    logic [31:0] env_word;

    assign core_hit = host_wr.en && (host_wr.core == 3'(CORE_ID));
    assign cmd_we   = core_hit && (host_wr.sel == CMD_MEM);
    assign env_we   = core_hit && (host_wr.sel == ENV_MEM);

    aligned_ram #(
        .DIN_WIDTH       (32),
        .N_DIN_TO_DOUT   (4),
        .DOUT_ADDR_WIDTH (CMD_ADDR_W),
        .READ_LATENCY    (2)
    ) u_cmd_mem (
        .clk          (clk),
        .write_data   (host_wr.data),
        .write_addr   (host_wr.addr[CMD_ADDR_W+1:0]),    // four words per command.
        .write_enable (cmd_we),
        .read_addr    (cmd_addr),
        .read_data    (cmd_data)
    );

    aligned_ram #(
        .DIN_WIDTH       (32),
        .N_DIN_TO_DOUT   (1),
        .DOUT_ADDR_WIDTH (ENV_ADDR_W),
        .READ_LATENCY    (2)
    ) u_env_mem (
        .clk          (clk),
        .write_data   (host_wr.data),
        .write_addr   (host_wr.addr[ENV_ADDR_W-1:0]),
        .write_enable (env_we),
        .read_addr    (env_addr),
        .read_data    (env_word)
    );

    assign env_data = env_word[15:0];    // sample in low half.

endmodule

/* proc_core/pulse_sequencer.sv */
module pulse_sequencer
    import dsp_pkg::*;
#(
    parameter int CMD_ADDR_W = 6,
    parameter int ENV_ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stb_start,
    input  logic [31:0]           nshot,
    input  cmd_u                  cmd_data,
    input  sample_t               env_data,
    input  logic                  acq_busy,
    output logic [CMD_ADDR_W-1:0] cmd_addr,
    output logic [ENV_ADDR_W-1:0] env_addr,
    output dac_out_t              dac,
    output logic                  acq_go,
    output logic [31:0]           acq_len,
    output logic [31:0]           shot,
    output logic                  busy,
    output logic                  done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_PLAY,
        S_ACQ_GO,
        S_ACQ_HOLD,
        S_WAIT
    } state_e;

    state_e             state;
    logic               fetch_wait;
    logic [31:0]        nshot_r;
    logic [31:0]        wait_cnt;
    logic [9:0]         env_left;
    amp_t               amp_r;
    logic               rd_v1;
    logic               rd_v2;
    logic               dac_valid;
    sample_t            dac_sample;
    logic signed [31:0] product;
    logic signed [31:0] scaled;

    assign product = env_data * amp_r;
    assign scaled  = product >>> 15;
    assign dac     = '{valid: dac_valid, data: dac_sample};

    // tracks reads through the two-cycle envelope ram.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_v1     <= 1'b0;
            rd_v2     <= 1'b0;
            dac_valid <= 1'b0;
        end else begin
            rd_v1     <= (state == S_PLAY) && (env_left != '0);
            rd_v2     <= rd_v1;
            dac_valid <= rd_v2;
        end
    end

    always_ff @(posedge clk) begin
        if (scaled > 32'sd32767)
            dac_sample <= 16'sh7fff;
        else if (scaled < -32'sd32768)
            dac_sample <= 16'sh8000;
        else
            dac_sample <= scaled[15:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            fetch_wait <= 1'b0;
            cmd_addr   <= '0;
            env_addr   <= '0;
            env_left   <= '0;
            amp_r      <= '0;
            wait_cnt   <= '0;
            nshot_r    <= '0;
            shot       <= '0;
            acq_go     <= 1'b0;
            acq_len    <= '0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            acq_go <= 1'b0;
            done   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (stb_start) begin
                        nshot_r    <= nshot;
                        shot       <= '0;
                        cmd_addr   <= '0;
                        fetch_wait <= 1'b0;
                        busy       <= 1'b1;
                        state      <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    fetch_wait <= 1'b1;
                    if (fetch_wait)
                        state <= S_DECODE;    // command word valid next cycle.
                end
                S_DECODE: begin
                    case (cmd_data.play.opcode)
                        PLAY: begin
                            env_addr <= ENV_ADDR_W'(cmd_data.play.env_start);
                            env_left <= cmd_data.play.env_len;
                            amp_r    <= cmd_data.play.amp;
                            state    <= S_PLAY;
                        end
                        ACQ: begin
                            acq_go  <= 1'b1;
                            acq_len <= cmd_data.ctrl.count;
                            state   <= S_ACQ_GO;
                        end
                        WAIT: begin
                            wait_cnt <= cmd_data.ctrl.count;
                            state    <= S_WAIT;
                        end
                        default: begin
                            // end of shot.
                            if (shot + 32'd1 >= nshot_r) begin
                                busy  <= 1'b0;
                                done  <= 1'b1;
                                state <= S_IDLE;
                            end else begin
                                shot       <= shot + 32'd1;
                                cmd_addr   <= '0;
                                fetch_wait <= 1'b0;
                                state      <= S_FETCH;
                            end
                        end
                    endcase
                end
                S_PLAY: begin
                    if (env_left != '0) begin
                        env_addr <= env_addr + 1'b1;
                        env_left <= env_left - 1'b1;
                    end else if (!rd_v1 && !rd_v2) begin
                        cmd_addr   <= cmd_addr + 1'b1;
                        fetch_wait <= 1'b0;
                        state      <= S_FETCH;
                    end
                end
                S_ACQ_GO: begin
                    state <= S_ACQ_HOLD;    // busy rises this cycle.
                end
                S_ACQ_HOLD: begin
                    if (!acq_busy) begin
                        cmd_addr   <= cmd_addr + 1'b1;
                        fetch_wait <= 1'b0;
                        state      <= S_FETCH;
                    end
                end
                default: begin
                    if (wait_cnt <= 32'd1) begin
                        cmd_addr   <= cmd_addr + 1'b1;
                        fetch_wait <= 1'b0;
                        state      <= S_FETCH;
                    end else begin
                        wait_cnt <= wait_cnt - 32'd1;
                    end
                end
            endcase
        end
    end

endmodule

/* proc_core/shot_accumulator.sv */
module shot_accumulator
    import dsp_pkg::*;
    import mem_pkg::*;
#(
    parameter int BUF_ADDR_W = 10
) (
    input  logic        clk,
    input  logic        arst_n,
    input  sample_t     adc,
    input  logic        acq_go,
    input  logic [31:0] acq_len,
    input  logic [31:0] shot,
    output logic        acq_busy,
    output acq_wr_t     acq_wr,
    output acc_wr_t     acc_wr
);

    logic [31:0]           remaining;
    logic [BUF_ADDR_W-1:0] wr_idx;
    logic [BUF_ADDR_W-1:0] shot_idx;
    acc_t                  sum;
    acc_t                  next_sum;
    logic                  capture;
    logic                  acq_we;
    logic [BUF_ADDR_W-1:0] acq_addr;
    sample_t               acq_data;
    logic                  acc_we;
    acc_t                  acc_data;

    assign capture  = acq_busy && (remaining != '0);
    assign next_sum = capture ? sum + acc_t'(adc) : sum;

    assign acq_wr = '{we: acq_we, addr: BUF_AW'(acq_addr), data: acq_data};
    assign acc_wr = '{we: acc_we, addr: BUF_AW'(shot_idx), data: acc_data};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acq_busy  <= 1'b0;
            remaining <= '0;
            wr_idx    <= '0;
            shot_idx  <= '0;
            sum       <= '0;
            acq_we    <= 1'b0;
            acc_we    <= 1'b0;
        end else begin
            acq_we <= capture;
            acc_we <= 1'b0;
            if (acq_go && !acq_busy) begin
                acq_busy  <= 1'b1;
                remaining <= acq_len;
                wr_idx    <= '0;
                shot_idx  <= shot[BUF_ADDR_W-1:0];
                sum       <= '0;
            end else if (acq_busy) begin
                if (capture) begin
                    remaining <= remaining - 32'd1;
                    wr_idx    <= wr_idx + 1'b1;
                end
                sum <= next_sum;
                if (remaining <= 32'd1) begin
                    acq_busy <= 1'b0;    // sum goes out with busy low.
                    acc_we   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        acq_addr <= wr_idx;
        acq_data <= adc;
        acc_data <= next_sum;
    end

endmodule

/* source/dsp_sim_toplevel.sv */
module dsp_sim_toplevel
    import dsp_pkg::*;
    import mem_pkg::*;
#(
    parameter int NPROC      = 3,
    parameter int CMD_ADDR_W = 6,
    parameter int ENV_ADDR_W = 10,
    parameter int BUF_ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stb_start,
    input  logic [31:0]           nshot,
    input  host_wr_t              host_wr,
    input  logic [BUF_ADDR_W-1:0] buf_read_addr,
    input  sample_t               adc [NPROC],
    output dac_out_t              dac [NPROC],
    output acc_t                  acc_read_data [NPROC],
    output sample_t               acq_read_data [NPROC],
    output logic [NPROC-1:0]      busy,
    output logic [NPROC-1:0]      done
);

    for (genvar g = 0; g < NPROC; g++) begin : g_core
        logic [CMD_ADDR_W-1:0] cmd_addr;
        cmd_u                  cmd_data;
        logic [ENV_ADDR_W-1:0] env_addr;
        sample_t               env_data;
        logic                  acq_go;
        logic [31:0]           acq_len;
        logic [31:0]           shot;
        logic                  acq_busy;
        acq_wr_t               acq_wr;
        acc_wr_t               acc_wr;

        elem_mems #(
            .CORE_ID    (g),
            .CMD_ADDR_W (CMD_ADDR_W),
            .ENV_ADDR_W (ENV_ADDR_W)
        ) u_mems (
            .clk      (clk),
            .host_wr  (host_wr),
            .cmd_addr (cmd_addr),
            .cmd_data (cmd_data),
            .env_addr (env_addr),
            .env_data (env_data)
        );

        pulse_sequencer #(
            .CMD_ADDR_W (CMD_ADDR_W),
            .ENV_ADDR_W (ENV_ADDR_W)
        ) u_seq (
            .clk       (clk),
            .arst_n    (arst_n),
            .stb_start (stb_start),
            .nshot     (nshot),
            .cmd_data  (cmd_data),
            .env_data  (env_data),
            .acq_busy  (acq_busy),
            .cmd_addr  (cmd_addr),
            .env_addr  (env_addr),
            .dac       (dac[g]),
            .acq_go    (acq_go),
            .acq_len   (acq_len),
            .shot      (shot),
            .busy      (busy[g]),
            .done      (done[g])
        );

        shot_accumulator #(
            .BUF_ADDR_W (BUF_ADDR_W)
        ) u_acc (
            .clk      (clk),
            .arst_n   (arst_n),
            .adc      (adc[g]),
            .acq_go   (acq_go),
            .acq_len  (acq_len),
            .shot     (shot),
            .acq_busy (acq_busy),
            .acq_wr   (acq_wr),
            .acc_wr   (acc_wr)
        );

        aligned_ram #(
            .DIN_WIDTH       (16),
            .N_DIN_TO_DOUT   (1),
            .DOUT_ADDR_WIDTH (BUF_ADDR_W),
            .READ_LATENCY    (1)
        ) u_acq_buf (
            .clk          (clk),
            .write_data   (acq_wr.data),
            .write_addr   (acq_wr.addr[BUF_ADDR_W-1:0]),
            .write_enable (acq_wr.we),
            .read_addr    (buf_read_addr),
            .read_data    (acq_read_data[g])
        );

        aligned_ram #(
            .DIN_WIDTH       (32),
            .N_DIN_TO_DOUT   (1),
            .DOUT_ADDR_WIDTH (BUF_ADDR_W),
            .READ_LATENCY    (1)
        ) u_acc_buf (
            .clk          (clk),
            .write_data   (acc_wr.data),
            .write_addr   (acc_wr.addr[BUF_ADDR_W-1:0]),    // one entry per shot.
            .write_enable (acc_wr.we),
            .read_addr    (buf_read_addr),
            .read_data    (acc_read_data[g])
        );
    end

endmodule

/* verification/tb_dsp_sim.sv */
module tb_dsp_sim
    import dsp_pkg::*;
    import mem_pkg::*;
();

    localparam int NPROC  = 3;
    localparam int NSHOT  = 4;
    localparam int NTESTS = 5;

    logic             clk;
    logic             arst_n;
    logic             stb_start;
    logic [31:0]      nshot;
    host_wr_t         host_wr;
    logic [9:0]       buf_read_addr;
    sample_t          adc [NPROC];
    dac_out_t         dac [NPROC];
    acc_t             acc_read_data [NPROC];
    sample_t          acq_read_data [NPROC];
    logic [NPROC-1:0] busy;
    logic [NPROC-1:0] done;

    int               seed;
    sample_t          adc_k [NPROC];
    int               acq_len_m [NPROC];
    int               shot_est [NPROC];
    sample_t          shot_q [NPROC][$];
    sample_t          exp_q [NPROC][$];
    int               done_cnt [NPROC];
    int               test_err [NTESTS];
    string            test_name [NTESTS];
    logic             running;
    int               run_cycles;
    int               cycle_limit;
    int               total_err;
    int               failed_tests;
    int               max_len;

    dsp_sim_toplevel #(
        .NPROC      (NPROC),
        .CMD_ADDR_W (6),
        .ENV_ADDR_W (10),
        .BUF_ADDR_W (10)
    ) u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .stb_start     (stb_start),
        .nshot         (nshot),
        .host_wr       (host_wr),
        .buf_read_addr (buf_read_addr),
        .adc           (adc),
        .dac           (dac),
        .acc_read_data (acc_read_data),
        .acq_read_data (acq_read_data),
        .busy          (busy),
        .done          (done)
    );

    always #10 clk = ~clk;

    // expected dac sample: product shifted down by 15, clipped to 16 bits.
    function automatic sample_t scale_sample(input sample_t s, input amp_t a);
        longint p;
        p = (longint'(s) * longint'(a)) >>> 15;
        if (p > 32767)
            return 16'sh7fff;
        if (p < -32768)
            return 16'sh8000;
        return sample_t'(p);
    endfunction

    function automatic logic all_done();
        logic seen;
        seen = 1'b1;
        for (int c = 0; c < NPROC; c++) begin
            if (done_cnt[c] == 0)
                seen = 1'b0;
        end
        return seen;
    endfunction

    task automatic check_value(input int test, input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got == want) else begin
            $display("mismatch %s: expected %h, got %h", name, want, got);
            test_err[test]++;
        end
    endtask

    task automatic host_write(input int c, input mem_sel_e sel, input int addr,
                              input logic [31:0] data);
        host_wr.en   = 1'b1;
        host_wr.core = 3'(c);
        host_wr.sel  = sel;
        host_wr.addr = 16'(addr);
        host_wr.data = data;
        @(negedge clk);
        host_wr.en   = 1'b0;
    endtask

    task automatic load_command(input int c, input int idx, input cmd_u cmd);
        for (int j = 0; j < 4; j++) begin
            host_write(c, CMD_MEM, idx * 4 + j, cmd[j*32 +: 32]);    // word 3 holds opcode.
        end
    endtask

    task automatic add_play(input int c, input int idx, input int start, input int len,
                            input amp_t gain);
        cmd_u    cmd;
        sample_t s;
        cmd                = '0;
        cmd.play.opcode    = PLAY;
        cmd.play.env_start = 10'(start);
        cmd.play.env_len   = 10'(len);
        cmd.play.amp       = gain;
        for (int i = 0; i < len; i++) begin
            s = sample_t'($random(seed));
            if (gain == 16'sh8000 && i == 0)
                s = 16'sh8000;    // full scale times full scale clips.
            host_write(c, ENV_MEM, start + i, {16'h0, s});
            shot_q[c].push_back(scale_sample(s, gain));
        end
        load_command(c, idx, cmd);
        shot_est[c] += len + 7;
    endtask

    task automatic add_ctrl(input int c, input int idx, input opcode_e op, input int count);
        cmd_u cmd;
        cmd            = '0;
        cmd.ctrl.opcode = op;
        cmd.ctrl.count  = 32'(count);
        load_command(c, idx, cmd);
        if (op == ACQ)
            acq_len_m[c] = count;
        shot_est[c] += (op == ACQ) ? count + 7 : count + 3;
    endtask

    task automatic report_test(input int t);
        $display("test %-22s %s, %0d errors", test_name[t], (test_err[t] == 0) ? "ok" : "failed",
                 test_err[t]);
    endtask

    // dac checker, one queue per core.
    always @(negedge clk) begin
        sample_t want;
        if (arst_n) begin
            for (int c = 0; c < NPROC; c++) begin
                if (done[c])
                    done_cnt[c]++;
                if (dac[c].valid) begin
                    assert (exp_q[c].size() != 0) else begin
                        $display("core %0d produced a dac sample beyond the expected count", c);
                        test_err[2]++;
                    end
                    if (exp_q[c].size() != 0) begin
                        want = exp_q[c].pop_front();
                        check_value(0, $sformatf("dac[%0d].data", c), 32'(want),
                                    32'(dac[c].data));
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            run_cycles++;
            if (run_cycles > cycle_limit) begin
                $display("timeout: done did not arrive on every core within %0d cycles",
                         cycle_limit);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        stb_start     = 1'b0;
        nshot         = '0;
        host_wr       = '0;
        buf_read_addr = '0;
        running       = 1'b0;
        run_cycles    = 0;
        seed          = 32'h12b6_f826;
        test_name     = '{"isolation_and_scaling", "shot_repetition", "start_while_busy",
                          "acq_buffer", "accumulation"};
        for (int c = 0; c < NPROC; c++) begin
            adc[c] = '0;
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // each core gets its own lengths, gains and random envelopes.
        cycle_limit = 0;
        for (int c = 0; c < NPROC; c++) begin
            adc_k[c] = sample_t'($random(seed));
            adc[c]   = adc_k[c];
            add_play(c, 0, 0, 6 + c, amp_t'(32'sh2000 + c * 32'sh1000));
            add_ctrl(c, 1, WAIT, 5 + c);
            add_play(c, 2, 16, 4 + c, amp_t'(-32'sh3000 - c * 32'sh0100));
            add_play(c, 3, 32, 3, 16'sh8000);
            add_ctrl(c, 4, WAIT, 3);
            add_ctrl(c, 5, ACQ, 8 + 2 * c);
            add_ctrl(c, 6, DONE, 0);
            for (int s = 0; s < NSHOT; s++) begin
                for (int i = 0; i < shot_q[c].size(); i++)
                    exp_q[c].push_back(shot_q[c][i]);
            end
            if (shot_est[c] * NSHOT * 2 + 200 > cycle_limit)
                cycle_limit = shot_est[c] * NSHOT * 2 + 200;
        end

        nshot     = 32'(NSHOT);
        stb_start = 1'b1;
        running   = 1'b1;
        @(negedge clk);
        stb_start = 1'b0;
        repeat (10) @(negedge clk);
        assert (busy == '1) else begin
            $display("busy was not high on every core when the second start was sent");
            test_err[2]++;
        end
        stb_start = 1'b1;    // second start, must be ignored.
        @(negedge clk);
        stb_start = 1'b0;
        while (!all_done())
            @(negedge clk);
        running = 1'b0;
        repeat (20) @(negedge clk);

        report_test(0);
        for (int c = 0; c < NPROC; c++) begin
            assert (done_cnt[c] == 1 && busy[c] == 1'b0) else begin
                $display("core %0d: done pulsed %0d times, busy %b after the run", c,
                         done_cnt[c], busy[c]);
                test_err[1]++;
            end
            assert (exp_q[c].size() == 0) else begin
                $display("core %0d: %0d expected dac samples never arrived", c,
                         exp_q[c].size());
                test_err[1]++;
            end
        end
        report_test(1);
        report_test(2);

        max_len = 0;
        for (int c = 0; c < NPROC; c++) begin
            if (acq_len_m[c] > max_len)
                max_len = acq_len_m[c];
        end
        for (int a = 0; a <= max_len; a++) begin
            buf_read_addr = 10'(a);
            @(negedge clk);
            for (int c = 0; c < NPROC; c++) begin
                if (a <= acq_len_m[c])
                    check_value(3, $sformatf("acq_read_data[%0d] @%0d", c, a),
                                32'((a < acq_len_m[c]) ? adc_k[c] : 16'sh0),
                                32'(acq_read_data[c]));
            end
        end
        report_test(3);

        for (int s = 0; s < NSHOT; s++) begin
            buf_read_addr = 10'(s);
            @(negedge clk);
            for (int c = 0; c < NPROC; c++) begin
                check_value(4, $sformatf("acc_read_data[%0d] @%0d", c, s),
                            32'(acq_len_m[c] * int'(adc_k[c])), 32'(acc_read_data[c]));
            end
        end
        report_test(4);

        total_err    = 0;
        failed_tests = 0;
        for (int t = 0; t < NTESTS; t++) begin
            total_err += test_err[t];
            if (test_err[t] != 0)
                failed_tests++;
        end
        $display("%0d tests run, %0d failed, %0d errors", NTESTS, failed_tests, total_err);
        if (total_err == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* flist.f */
common/dsp_pkg.sv
common/mem_pkg.sv
source/aligned_ram.sv
proc_core/elem_mems.sv
proc_core/pulse_sequencer.sv
proc_core/shot_accumulator.sv
source/dsp_sim_toplevel.sv
verification/tb_dsp_sim.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dsp_sim
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
